// ==== include/uart_cfg.svh ====
// Build settings for the UART relay, included by the RTL and by the testbench
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Line timing

`define UART_HALF_BIT 4          // Clocks per half bit, full bit is twice this

// Line format

`define UART_PARITY_ODD 0        // 1 selects odd parity, 0 selects even

// Buffering between the two lines

`define RELAY_FIFO_DEPTH 4       // Entries, power of two and at least 2

`endif

// ==== source/uart_pkg.sv ====
// Line format of the relay UART frames, imported by the receiver and the transmitter
`default_nettype none

package uart_pkg;

    typedef enum logic {
        parity_even = 1'b0,
        parity_odd  = 1'b1
    } parity_mode_t;

    localparam int UART_DATA_BITS  = 8;     // Payload bits per frame
    localparam int UART_FRAME_BITS = 11;    // Start, data, parity, stop

    // Parity bit that goes on the line after the data
    function automatic logic parity_bit(
        input logic [UART_DATA_BITS-1:0] data,
        input parity_mode_t              mode
    );
        return (^data) ^ (mode == parity_odd);
    endfunction

endpackage

`default_nettype wire

// ==== source/relay_pkg.sv ====
// Buffered data of the relay node, imported by the receiver, the FIFO, the transmitter and the top
`default_nettype none

package relay_pkg;

    import uart_pkg::*;

    // One received byte as it waits in the FIFO
    typedef struct packed {
        logic [UART_DATA_BITS-1:0] data;
        logic                      parity_err;    // Set when the line parity did not match
    } relay_word_t;

    localparam int ERR_COUNT_W = 8;    // Dropped byte counter, saturating

endpackage

`default_nettype wire

// ==== source/uart_rx.sv ====
// UART receiver of the relay, samples the rx line mid-bit and strobes out each byte with its parity check
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_rx
    import uart_pkg::*, relay_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        rx,
    output relay_word_t rx_word,
    output logic        rx_done
);

    localparam int CNT_W = $clog2(2 * `UART_HALF_BIT);
    localparam int IDX_W = $clog2(UART_FRAME_BITS);
    localparam logic [CNT_W-1:0] HALF_LAST  = CNT_W'(`UART_HALF_BIT - 1);
    localparam logic [CNT_W-1:0] FULL_LAST  = CNT_W'(2 * `UART_HALF_BIT - 1);
    localparam logic [IDX_W-1:0] STOP_INDEX = IDX_W'(UART_FRAME_BITS - 2);
    localparam parity_mode_t     PARITY     = parity_mode_t'(`UART_PARITY_ODD);

    typedef enum logic [1:0] {
        st_init,
        st_idle,
        st_start,
        st_receive
    } rx_state_t;

    rx_state_t               state;
    logic                    rx_q;          // Registered line
    logic [CNT_W-1:0]        clk_count;
    logic [IDX_W-1:0]        bit_index;
    logic [UART_DATA_BITS:0] shift_reg;     // Parity ends up in the top bit

    assign rx_word.data       = shift_reg[UART_DATA_BITS-1:0];
    assign rx_word.parity_err = parity_bit(shift_reg[UART_DATA_BITS-1:0], PARITY)
                                != shift_reg[UART_DATA_BITS];

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_init;
            rx_q    <= 1'b1;                // Idle line level
            rx_done <= 1'b0;
        end else begin
            rx_q    <= rx;
            rx_done <= 1'b0;
            case (state)
                st_init: begin
                    clk_count <= '0;
                    bit_index <= '0;
                    state     <= st_idle;
                end
                st_idle: begin
                    if (!rx_q) begin
                        clk_count <= CNT_W'(1);     // Falling edge already took a clock
                        bit_index <= '0;
                        state     <= st_start;
                    end
                end
                st_start: begin
                    if (clk_count == HALF_LAST) begin
                        clk_count <= '0;            // Now in the middle of the start bit
                        state     <= st_receive;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                st_receive: begin
                    if (clk_count == FULL_LAST) begin
                        clk_count <= '0;
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == STOP_INDEX) begin
                            rx_done <= 1'b1;        // Stop bit sampled, not checked
                            state   <= st_idle;
                        end else begin
                            shift_reg <= {rx_q, shift_reg[UART_DATA_BITS:1]};
                        end
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                default: state <= st_init;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/relay_fifo.sv ====
// Circular FIFO between receiver and transmitter, flags a sticky overrun when a byte is lost
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module relay_fifo
    import relay_pkg::*;
#(
    parameter int DEPTH = `RELAY_FIFO_DEPTH
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        push,
    input  relay_word_t wr_word,
    input  logic        pop,
    output relay_word_t rd_word,
    output logic        empty,
    output logic        overrun
);

    localparam int PTR_W = $clog2(DEPTH);

    relay_word_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full    = count == (PTR_W + 1)'(DEPTH);
    assign empty   = count == '0;
    assign rd_word = mem[rd_ptr];
    assign rd_en   = pop && !empty;
    assign wr_en   = push && (!full || rd_en);  // A pop frees the slot on the same edge

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;        // Wraps since depth is a power of two
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && !wr_en) begin
                overrun <= 1'b1;                // Held until reset
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
// UART transmitter of the relay, pops buffered bytes, drops bad ones and sends good ones
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_tx
    import uart_pkg::*, relay_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  relay_word_t            rd_word,
    input  logic                   empty,
    input  logic                   cts,
    output logic                   pop,
    output logic                   tx,
    output logic [ERR_COUNT_W-1:0] parity_err_count
);

    localparam int CNT_W = $clog2(2 * `UART_HALF_BIT);
    localparam int IDX_W = $clog2(UART_FRAME_BITS);
    localparam logic [CNT_W-1:0] FULL_LAST  = CNT_W'(2 * `UART_HALF_BIT - 1);
    localparam logic [IDX_W-1:0] LAST_INDEX = IDX_W'(UART_FRAME_BITS - 2);
    localparam parity_mode_t     PARITY     = parity_mode_t'(`UART_PARITY_ODD);

    typedef enum logic [1:0] {
        st_idle,
        st_shift,
        st_stop
    } tx_state_t;

    tx_state_t               state;
    logic [CNT_W-1:0]        bit_timer;
    logic [IDX_W-1:0]        bit_index;     // Bits sent after the start bit
    logic [UART_DATA_BITS:0] shift_reg;     // Data then parity, LSB out first

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= st_idle;
            bit_timer        <= '0;
            bit_index        <= '0;
            pop              <= 1'b0;
            tx               <= 1'b1;
            parity_err_count <= '0;
        end else begin
            pop <= 1'b0;
            case (state)
                st_idle: begin
                    bit_timer <= '0;
                    bit_index <= '0;
                    if (pop) begin
                        if (rd_word.parity_err) begin
                            if (parity_err_count != '1) begin
                                parity_err_count <= parity_err_count + 1'b1;
                            end
                        end else begin
                            shift_reg <= {parity_bit(rd_word.data, PARITY), rd_word.data};
                            tx        <= 1'b0;      // Start bit
                            state     <= st_shift;
                        end
                    end else if (!empty && cts) begin
                        pop <= 1'b1;
                    end
                end
                st_shift: begin
                    if (bit_timer == FULL_LAST) begin
                        bit_timer <= '0;
                        if (bit_index == LAST_INDEX) begin
                            tx    <= 1'b1;          // Stop bit
                            state <= st_stop;
                        end else begin
                            tx        <= shift_reg[0];
                            shift_reg <= shift_reg >> 1;
                            bit_index <= bit_index + 1'b1;
                        end
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                st_stop: begin
                    if (bit_timer == FULL_LAST) begin
                        bit_timer <= '0;
                        state     <= st_idle;
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/uart_relay.sv ====
// Top of the UART relay node, receiver feeding the transmitter through a small FIFO
`timescale 1ns/1ps
`default_nettype none

module uart_relay
    import relay_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rx,
    input  logic                   cts,
    output logic                   tx,
    output logic [ERR_COUNT_W-1:0] parity_err_count,
    output logic                   overrun
);

    relay_word_t rx_word;
    relay_word_t rd_word;
    logic        rx_done;
    logic        empty;
    logic        pop;

    uart_rx uart_rx_i (
        .clk     (clk),
        .reset   (reset),
        .rx      (rx),
        .rx_word (rx_word),
        .rx_done (rx_done)
    );

    relay_fifo relay_fifo_i (
        .clk     (clk),
        .reset   (reset),
        .push    (rx_done),         // Every received byte, good or bad
        .wr_word (rx_word),
        .pop     (pop),
        .rd_word (rd_word),
        .empty   (empty),
        .overrun (overrun)
    );

    uart_tx uart_tx_i (
        .clk              (clk),
        .reset            (reset),
        .rd_word          (rd_word),
        .empty            (empty),
        .cts              (cts),
        .pop              (pop),
        .tx               (tx),
        .parity_err_count (parity_err_count)
    );

endmodule

`default_nettype wire

// ==== test/uart_relay_assert.sv ====
// Concurrent checks on the relay FIFO and transmitter, bound into both modules at the end
`timescale 1ns/1ps
`default_nettype none

module uart_relay_assert (
    input logic clk,
    input logic reset,
    input logic pop,
    input logic empty,
    input logic overrun,
    input logic tx,
    input logic tx_idle
);

    pop_needs_data: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
        else $error("pop raised while the FIFO is empty");

    idle_line_high: assert property (@(posedge clk) disable iff (reset) tx_idle |-> tx)
        else $error("tx low while the transmitter is idle");

    // Only a reset may clear it
    overrun_sticky: assert property (@(posedge clk) disable iff (reset) !$fell(overrun))
        else $error("overrun fell without a reset");

endmodule

bind relay_fifo uart_relay_assert fifo_checks (
    .clk     (clk),
    .reset   (reset),
    .pop     (pop),
    .empty   (empty),
    .overrun (overrun),
    .tx      (1'b1),
    .tx_idle (1'b0)
);

bind uart_tx uart_relay_assert tx_checks (
    .clk     (clk),
    .reset   (reset),
    .pop     (pop),
    .empty   (empty),
    .overrun (1'b0),
    .tx      (tx),
    .tx_idle (state == st_idle)
);

`default_nettype wire

// ==== test/uart_relay_tb.sv ====
// Directed testbench for the UART relay, drives frames on rx and decodes what comes out on tx
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_relay_tb
    import relay_pkg::*;
();

    localparam int   CLK_PERIOD    = 8;
    localparam int   BIT_CLKS      = 2 * `UART_HALF_BIT;
    localparam int   FRAME_CLKS    = 11 * BIT_CLKS;
    localparam int   DEPTH         = `RELAY_FIFO_DEPTH;
    localparam int   TOTAL_FRAMES  = 1 + 5 + 3 + (DEPTH + 2) + 20;
    localparam int   MARGIN_FRAMES = 30;        // Covers drain and quiet waits
    localparam logic ODD           = 1'(`UART_PARITY_ODD);

    logic                   clk;
    logic                   reset;
    logic                   rx;
    logic                   cts;
    logic                   tx;
    logic [ERR_COUNT_W-1:0] parity_err_count;
    logic                   overrun;
    logic [7:0]             rx_bytes [$];       // Decoded from tx, oldest first
    int                     errors;
    int                     test_count;
    int                     bad_frames;         // Frames sent with a wrong parity bit
    logic [15:0]            lfsr_state;

    uart_relay uart_relay_i (
        .clk              (clk),
        .reset            (reset),
        .rx               (rx),
        .cts              (cts),
        .tx               (tx),
        .parity_err_count (parity_err_count),
        .overrun          (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((TOTAL_FRAMES + MARGIN_FRAMES) * FRAME_CLKS * CLK_PERIOD);
        $display("Watchdog expired before all tests completed");
        $display("Finished with errors");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic random_byte(output logic [7:0] value);
        int i;
        for (i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value[i]   = lfsr_state[0];
        end
    endtask

    // Start, data LSB first, parity, stop; each bit held for one bit period
    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] frame;
        int          i;
        frame = {1'b1, (^data) ^ ODD ^ bad_parity, data, 1'b0};
        if (bad_parity) begin
            bad_frames++;
        end
        for (i = 0; i < 11; i++) begin
            rx = frame[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
    endtask

    task automatic watch_tx();
        logic [8:0] bits;
        int         i;
        forever begin
            @(negedge tx);
            repeat (`UART_HALF_BIT) @(negedge clk);     // Middle of the start bit
            check_value("tx start bit", 32'(tx), 32'(0));
            for (i = 0; i < 9; i++) begin
                repeat (BIT_CLKS) @(negedge clk);
                bits[i] = tx;
            end
            repeat (BIT_CLKS) @(negedge clk);
            check_value("tx stop bit", 32'(tx), 32'(1));
            check_value("tx parity bit", 32'(bits[8]), 32'((^bits[7:0]) ^ ODD));
            rx_bytes.push_back(bits[7:0]);
        end
    endtask

    task automatic wait_for_bytes(input int count);
        int waited;
        waited = 0;
        while (rx_bytes.size() < count && waited < (count + 2) * FRAME_CLKS) begin
            @(negedge clk);
            waited++;
        end
        if (rx_bytes.size() < count) begin
            $display("Timed out waiting for %0d bytes on tx, only %0d came", count,
                     rx_bytes.size());
            errors++;
        end
    endtask

    task automatic compare_stream(input logic [7:0] sent [$]);
        int i;
        check_value("tx byte count", rx_bytes.size(), sent.size());
        for (i = 0; i < sent.size() && i < rx_bytes.size(); i++) begin
            check_value("tx byte", 32'(rx_bytes[i]), 32'(sent[i]));
        end
        rx_bytes.delete();
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("Test %0d %s: %0d errors", test_count, name, errors - errors_before);
    endtask

    task automatic single_byte_after_reset();
        int         start_errors;
        logic [7:0] sent [$];
        start_errors = errors;
        check_value("tx", 32'(tx), 32'(1));
        check_value("overrun", 32'(overrun), 32'(0));
        check_value("parity_err_count", 32'(parity_err_count), 32'(0));
        sent.push_back(8'ha5);
        send_frame(8'ha5, 1'b0);
        wait_for_bytes(1);
        compare_stream(sent);
        report_test("single byte after reset", start_errors);
    endtask

    task automatic five_frame_burst();
        int         start_errors;
        logic [7:0] sent [$];
        start_errors = errors;
        sent = {8'h00, 8'hff, 8'h3c, 8'h81, 8'h5a};
        foreach (sent[i]) send_frame(sent[i], 1'b0);  // No gap between frames
        wait_for_bytes(5);
        compare_stream(sent);
        report_test("five frame burst", start_errors);
    endtask

    task automatic drop_bad_parity();
        int         start_errors;
        logic [7:0] sent [$];
        start_errors = errors;
        sent = {8'h12, 8'h34};
        send_frame(8'h12, 1'b0);
        send_frame(8'hc7, 1'b1);
        send_frame(8'h34, 1'b0);
        wait_for_bytes(2);
        compare_stream(sent);
        check_value("parity_err_count", 32'(parity_err_count), bad_frames);
        report_test("drop bad parity", start_errors);
    endtask

    task automatic cts_back_pressure();
        int         start_errors;
        int         i;
        logic [7:0] sent [$];
        start_errors = errors;
        cts = 1'b0;
        for (i = 0; i < DEPTH + 2; i++) begin
            if (i < DEPTH) sent.push_back(8'(8'h40 + i));
            send_frame(8'(8'h40 + i), 1'b0);
        end
        repeat (BIT_CLKS) @(negedge clk);           // Last byte has reached the FIFO
        check_value("overrun", 32'(overrun), 32'(1));
        check_value("tx bytes while cts low", rx_bytes.size(), 0);
        cts = 1'b1;
        wait_for_bytes(DEPTH);
        repeat (2 * FRAME_CLKS) @(negedge clk);     // Lost bytes must not show up
        compare_stream(sent);
        report_test("cts back pressure", start_errors);
    endtask

    task automatic random_byte_stream();
        int         start_errors;
        int         i;
        logic [7:0] value;
        logic [7:0] sent [$];
        start_errors = errors;
        for (i = 0; i < 20; i++) begin
            random_byte(value);
            sent.push_back(value);
            send_frame(value, 1'b0);
        end
        wait_for_bytes(20);
        compare_stream(sent);
        check_value("parity_err_count", 32'(parity_err_count), bad_frames);
        report_test("random byte stream", start_errors);
    endtask

    initial begin
        errors     = 0;
        test_count = 0;
        bad_frames = 0;
        lfsr_state = 16'd73;
        reset      = 1'b1;
        rx         = 1'b1;                          // Idle line
        cts        = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);
        fork
            watch_tx();
        join_none
        single_byte_after_reset();
        five_frame_burst();
        drop_bad_parity();
        cts_back_pressure();
        random_byte_stream();
        $display("Tests run %0d, errors %0d", test_count, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
source/uart_pkg.sv
source/relay_pkg.sv
source/uart_rx.sv
source/relay_fifo.sv
source/uart_tx.sv
source/uart_relay.sv
test/uart_relay_assert.sv
test/uart_relay_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= uart_relay_tb
LINT_TOP   ?= uart_relay
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
